//--- flist.f
source/pq_pkg.sv
source/pq_flush_ctrl.sv
source/pq_bblk_queue.sv
source/pq_bpu_req.sv
source/pq_issue_pc.sv
source/pq_top.sv
sim/pq_tb_sva.sv
sim/pq_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module pq_tb -o pq_sim
out=$(./obj_dir/pq_sim +verilator+error+limit+1000)
echo "$out"
if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- sim/pq_tb.sv
// prediction queue testbench with BPU, queue, PC and break-flag reference models
`timescale 1ns/1ps
`default_nettype none

module pq_tb;
    import pq_pkg::*;

    localparam int N_CYCLES     = 3000;
    localparam int RESET_CYCLES = 5;
    localparam int CLK_PERIOD   = 20;

    logic core_clk, core_reset_n;
    logic resume, redirect, redirect_for_cti, retry;
    va_t  resume_pc, redirect_pc, retry_pc;
    logic bpu_rd_ready, bpu_rd_ack, bpu_info_hit, bpu_info_ret, bpu_info_pred_taken;
    va_t  bpu_info_target, bpu_info_start_pc;
    bblk_offset_t bpu_info_offset;
    hit_way_t     bpu_info_way;
    pred_cnt_t    bpu_info_pred_cnt;
    logic ifu_i0_issue, ifu_i0_32b, ifu_i0_pred_hit;
    logic ifu_i1_issue, ifu_i1_32b, ifu_i1_pred_hit, ifu_i1_bblk_start;
    logic bpu_rd_valid, no_addr_valid_stall;
    va_t  ifu_i0_pc, ifu_i0_pred_npc, ifu_i1_pc, ifu_i1_pred_npc;
    logic ifu_i0_pred_valid, ifu_i0_pred_taken, ifu_i0_pred_ret, ifu_i0_pred_brk;
    logic ifu_i1_pred_valid, ifu_i1_pred_taken, ifu_i1_pred_ret;
    hit_way_t  ifu_i0_pred_way, ifu_i1_pred_way;
    pred_cnt_t ifu_i0_pred_cnt, ifu_i1_pred_cnt;

    integer      seed;
    int          mism_cnt, other_cnt, hit_cnt, bpu_delay;
    bblk_entry_t q_m[$];
    va_t         last_t, pc_m;
    logic        brk_m, bpu_busy, full_seen;

    pq_top dut0 (.*);

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            mism_cnt++;
        end
    endtask

    task automatic check_slot(input string slot, input int idx, input logic hit,
                              input logic vld, input hit_way_t way, input logic taken,
                              input logic ret, input pred_cnt_t cnt, input va_t npc);
        logic        exp_v;
        bblk_entry_t e;
        va_t         exp_npc;
        exp_v = q_m.size() > idx;
        check({slot, "_pred_valid"}, 32'(vld), 32'(exp_v));
        if (exp_v) begin
            e       = q_m[idx];
            exp_npc = (q_m.size() > idx + 1) ? {q_m[idx + 1].start_pc, 1'b0} : last_t;
            check({slot, "_pred_way"}, 32'(way), 32'(e.way));
            check({slot, "_pred_cnt"}, 32'(cnt), 32'(e.cnt));
            check({slot, "_pred_ret"}, 32'(ret), 32'(e.ret));
            check({slot, "_pred_taken"}, 32'(taken), 32'(e.pred_taken & hit));
            check({slot, "_pred_npc"}, npc, exp_npc);
        end
    endtask

    task automatic check_outputs();
        va_t s0;
        s0 = ifu_i0_32b ? 32'd4 : 32'd2;
        check("ifu_i0_pc", ifu_i0_pc, pc_m);
        check("ifu_i1_pc", ifu_i1_pc, pc_m + s0);
        check("ifu_i0_pred_brk", 32'(ifu_i0_pred_brk), 32'(brk_m));
        check_slot("ifu_i0", 0, ifu_i0_pred_hit, ifu_i0_pred_valid, ifu_i0_pred_way,
                   ifu_i0_pred_taken, ifu_i0_pred_ret, ifu_i0_pred_cnt, ifu_i0_pred_npc);
        check_slot("ifu_i1", ifu_i1_bblk_start ? 1 : 0, ifu_i1_pred_hit, ifu_i1_pred_valid,
                   ifu_i1_pred_way, ifu_i1_pred_taken, ifu_i1_pred_ret, ifu_i1_pred_cnt,
                   ifu_i1_pred_npc);
    endtask

    // state after the coming rising edge
    task automatic update_models();
        bblk_entry_t e;
        if (resume | (redirect & redirect_for_cti)) begin
            brk_m = 1'b0;
        end else if ((redirect & ~redirect_for_cti) | (retry & ~redirect)) begin
            brk_m = 1'b1;
        end
        if (resume | redirect | retry) begin
            q_m.delete();
            pc_m     = resume ? resume_pc : redirect ? redirect_pc : retry_pc;
            bpu_busy = 1'b0;
        end else begin
            if (ifu_i0_issue) begin
                pc_m = pc_m + (ifu_i0_32b ? 32'd4 : 32'd2)
                     + (ifu_i1_issue ? (ifu_i1_32b ? 32'd4 : 32'd2) : 32'd0);
            end
            if (ifu_i0_issue & ifu_i0_pred_hit) begin
                if (q_m.size() == 0) begin
                    $display("slot i0 popped an empty queue");
                    other_cnt++;
                end else begin
                    void'(q_m.pop_front());
                end
            end
            if (ifu_i1_issue & ifu_i1_pred_hit) begin
                if (q_m.size() == 0) begin
                    $display("slot i1 popped an empty queue");
                    other_cnt++;
                end else begin
                    void'(q_m.pop_front());
                end
            end
            if (bpu_rd_ack && bpu_busy) begin
                bpu_busy = 1'b0;
                if (bpu_info_hit) begin
                    e.start_pc   = bpu_info_start_pc[31:1];
                    e.offset     = bpu_info_offset;
                    e.pred_taken = bpu_info_pred_taken;
                    e.way        = bpu_info_way;
                    e.cnt        = bpu_info_pred_cnt;
                    e.ret        = bpu_info_ret;
                    q_m.push_back(e);
                    last_t = bpu_info_target;
                    hit_cnt++;
                    if (q_m.size() == PQ_DEPTH) begin
                        full_seen = 1'b1;
                    end
                end
            end else if (bpu_rd_valid && bpu_rd_ready) begin
                bpu_busy  = 1'b1;
                bpu_delay = 1 + ($random(seed) & 3);
            end
        end
    endtask

    always @(negedge core_clk) begin
        if (core_reset_n) begin
            check_outputs();
            update_models();
        end
    end

    task automatic drive_cycle(input int c);
        logic [2:0] sel;
        logic       i0_iss, h0, i1_iss, h1;
        int         need;
        sel = 3'($random(seed));
        if (c == 10 || (c > 10 && ($random(seed) & 63) == 0)) begin
            // at least one flush source
            if (sel == 3'd0) begin
                sel = 3'd4;
            end
        end else begin
            sel = 3'd0;
        end
        resume           <= sel[0];
        redirect         <= sel[1];
        retry            <= sel[2];
        redirect_for_cti <= 1'($random(seed));
        resume_pc        <= 32'($random(seed)) & 32'hffff_fffe;
        redirect_pc      <= 32'($random(seed)) & 32'hffff_fffe;
        retry_pc         <= 32'($random(seed)) & 32'hffff_fffe;
        bpu_rd_ready     <= ($random(seed) & 3) != 0;
        if (bpu_busy && bpu_delay == 1) begin
            bpu_rd_ack          <= 1'b1;
            bpu_info_hit        <= ($random(seed) & 7) != 0;
            bpu_info_target     <= 32'($random(seed)) & 32'hffff_fffe;
            bpu_info_start_pc   <= 32'($random(seed)) & 32'hffff_fffe;
            bpu_info_offset     <= 10'($random(seed));
            bpu_info_way        <= 2'($random(seed));
            bpu_info_ret        <= 1'($random(seed));
            bpu_info_pred_taken <= 1'($random(seed));
            bpu_info_pred_cnt   <= 4'($random(seed));
            bpu_delay = 0;
        end else begin
            bpu_rd_ack <= 1'b0;
            if (bpu_busy && bpu_delay > 1) begin
                bpu_delay--;
            end
        end
        // never pop past the stored entries
        i0_iss = ($random(seed) & 3) == 0;
        // hold windows let the queue fill up
        if ((c / 200) % 4 == 1) begin
            i0_iss = 1'b0;
        end
        h0     = 1'($random(seed));
        if (i0_iss && q_m.size() < 1) begin
            h0 = 1'b0;
        end
        i1_iss = i0_iss & 1'($random(seed));
        h1     = 1'($random(seed));
        need   = (i0_iss && h0) ? 2 : 1;
        if (i1_iss && q_m.size() < need) begin
            h1 = 1'b0;
        end
        ifu_i0_issue      <= i0_iss;
        ifu_i0_pred_hit   <= h0;
        ifu_i0_32b        <= 1'($random(seed));
        ifu_i1_issue      <= i1_iss;
        ifu_i1_pred_hit   <= h1;
        ifu_i1_32b        <= 1'($random(seed));
        ifu_i1_bblk_start <= 1'($random(seed));
    endtask

    initial begin
        seed = 32'h13fc4903;
        {resume, redirect, redirect_for_cti, retry} = '0;
        {resume_pc, redirect_pc, retry_pc} = '0;
        {bpu_rd_ready, bpu_rd_ack, bpu_info_hit, bpu_info_ret, bpu_info_pred_taken} = '0;
        {bpu_info_target, bpu_info_start_pc, bpu_info_offset} = '0;
        {bpu_info_way, bpu_info_pred_cnt} = '0;
        {ifu_i0_issue, ifu_i0_32b, ifu_i0_pred_hit} = '0;
        {ifu_i1_issue, ifu_i1_32b, ifu_i1_pred_hit, ifu_i1_bblk_start} = '0;
        {mism_cnt, other_cnt, hit_cnt, bpu_delay} = '0;
        {last_t, pc_m, brk_m, bpu_busy, full_seen} = '0;
        core_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk);
        core_reset_n <= 1'b1;
        for (int c = 0; c < N_CYCLES; c++) begin
            @(posedge core_clk);
            drive_cycle(c);
        end
        @(posedge core_clk);
        if (hit_cnt == 0) begin
            $display("no BPU hit ack was accepted during the run");
            other_cnt++;
        end
        if (!full_seen) begin
            $display("the queue never held five entries during the run");
            other_cnt++;
        end
        $display("errors: mismatch=%0d other=%0d assertion=%0d",
                 mism_cnt, other_cnt, dut0.sva0.fail_cnt);
        if (mism_cnt == 0 && other_cnt == 0 && dut0.sva0.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((N_CYCLES + RESET_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired before the stimulus loop finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/pq_tb_sva.sv
// prediction queue protocol assertions, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module pq_tb_sva (
    input logic        core_clk,
    input logic        core_reset_n,
    input logic        resume,
    input pq_pkg::va_t resume_pc,
    input logic        redirect,
    input pq_pkg::va_t redirect_pc,
    input logic        retry,
    input pq_pkg::va_t retry_pc,
    input logic        bpu_rd_valid,
    input logic        bpu_rd_ready,
    input logic        bpu_rd_ack,
    input logic        bpu_info_hit,
    input logic        no_addr_valid_stall,
    input logic        ifu_i0_pred_valid,
    input logic        ifu_i1_pred_valid,
    input pq_pkg::va_t ifu_i0_pc,
    input logic [2:0]  entry_cnt
);
    import pq_pkg::*;

    int   fail_cnt = 0;
    logic flush_any;
    va_t  flush_pc;
    logic seen_flush;
    logic out_r;
    logic miss_r;

    assign flush_any = resume | redirect | retry;
    assign flush_pc  = resume ? resume_pc : redirect ? redirect_pc : retry_pc;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            seen_flush <= 1'b0;
            out_r      <= 1'b0;
            miss_r     <= 1'b0;
        end else if (flush_any) begin
            seen_flush <= 1'b1;
            out_r      <= 1'b0;
            miss_r     <= 1'b0;
        end else begin
            if (bpu_rd_valid && bpu_rd_ready) begin
                out_r <= 1'b1;
            end else if (bpu_rd_ack) begin
                out_r <= 1'b0;
            end
            if (bpu_rd_ack && out_r && !bpu_info_hit) begin
                miss_r <= 1'b1;
            end
        end
    end

    a_no_req_before_flush: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        !seen_flush |-> !bpu_rd_valid)
        else begin $error("request before the first flush"); fail_cnt++; end

    a_req_after_flush: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        flush_any |=> bpu_rd_valid)
        else begin $error("no request after a flush"); fail_cnt++; end

    a_one_outstanding: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        (out_r || entry_cnt == 3'd5) |-> !bpu_rd_valid)
        else begin $error("request while outstanding or full"); fail_cnt++; end

    a_req_when_idle: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        (seen_flush && !out_r && !miss_r && entry_cnt != 3'd5) |-> bpu_rd_valid)
        else begin $error("no request while idle and not full"); fail_cnt++; end

    a_miss_blocks: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        miss_r |-> !bpu_rd_valid)
        else begin $error("request after a miss ack"); fail_cnt++; end

    a_valid_holds: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        (bpu_rd_valid && !bpu_rd_ready && !flush_any) |-> no_addr_valid_stall ##1 bpu_rd_valid)
        else begin $error("stalled request dropped or no stall flag"); fail_cnt++; end

    a_stall_only_blocked: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        no_addr_valid_stall |-> bpu_rd_valid && !bpu_rd_ready)
        else begin $error("stall flag without a blocked request"); fail_cnt++; end

    a_flush_clears: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        flush_any |=> !ifu_i0_pred_valid && !ifu_i1_pred_valid && ifu_i0_pc == $past(flush_pc))
        else begin $error("flush did not clear the slots"); fail_cnt++; end

endmodule

bind pq_top pq_tb_sva sva0 (
    .core_clk            (core_clk),
    .core_reset_n        (core_reset_n),
    .resume              (resume),
    .resume_pc           (resume_pc),
    .redirect            (redirect),
    .redirect_pc         (redirect_pc),
    .retry               (retry),
    .retry_pc            (retry_pc),
    .bpu_rd_valid        (bpu_rd_valid),
    .bpu_rd_ready        (bpu_rd_ready),
    .bpu_rd_ack          (bpu_rd_ack),
    .bpu_info_hit        (bpu_info_hit),
    .no_addr_valid_stall (no_addr_valid_stall),
    .ifu_i0_pred_valid   (ifu_i0_pred_valid),
    .ifu_i1_pred_valid   (ifu_i1_pred_valid),
    .ifu_i0_pc           (ifu_i0_pc),
    .entry_cnt           (entry_cnt)
);

`default_nettype wire

//--- source/pq_bblk_queue.sv
// basic-block queue: five-entry circular store with write and issue pointers
`timescale 1ns/1ps
`default_nettype none

module pq_bblk_queue (
    input  logic                core_clk,
    input  logic                core_reset_n,
    input  pq_pkg::flush_t      flush,
    input  logic                wr_en,
    input  pq_pkg::bpu_info_t   bpu_info,
    input  logic [1:0]          pop_cnt,
    output logic                q_full,
    output logic [2:0]          entry_cnt,
    output pq_pkg::bblk_entry_t head_entry,
    output pq_pkg::bblk_entry_t next_entry,
    output pq_pkg::va_t         next2_pc,
    output pq_pkg::va_t         last_target
);
    import pq_pkg::*;

    bblk_entry_t mem [PQ_DEPTH];
    pq_ptr_t     wr_ptr;
    pq_ptr_t     iss_ptr;
    pq_ptr_t     iss_ptr_p1;
    pq_ptr_t     iss_ptr_p2;
    logic [2:0]  wr_idx;
    logic [2:0]  iss_idx;
    bblk_entry_t next2_entry;

    // index wraps from the last slot to zero and flips the wrap bit
    function automatic pq_ptr_t ptr_inc(input pq_ptr_t p);
        pq_ptr_t r;
        if (p[2:0] == PQ_LAST_IDX) begin
            r = {~p[3], 3'd0};
        end else begin
            r = p + 4'd1;
        end
        return r;
    endfunction

    assign wr_idx     = wr_ptr[2:0];
    assign iss_idx    = iss_ptr[2:0];
    assign iss_ptr_p1 = ptr_inc(iss_ptr);
    assign iss_ptr_p2 = ptr_inc(iss_ptr_p1);

    assign q_full    = (wr_idx == iss_idx) & (wr_ptr[3] != iss_ptr[3]);
    assign entry_cnt = (wr_ptr[3] == iss_ptr[3]) ? (wr_idx - iss_idx)
                                                 : (wr_idx + 3'(PQ_DEPTH) - iss_idx);

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_idx] <= bpu_info.entry;
            last_target <= bpu_info.target;
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            wr_ptr <= '0;
        end else if (flush.valid) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= ptr_inc(wr_ptr);
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            iss_ptr <= '0;
        end else if (flush.valid) begin
            iss_ptr <= '0;
        end else if (pop_cnt == 2'd2) begin
            iss_ptr <= iss_ptr_p2;
        end else if (pop_cnt == 2'd1) begin
            iss_ptr <= iss_ptr_p1;
        end
    end

    // combinational read ports at the head
    assign head_entry  = mem[iss_idx];
    assign next_entry  = mem[iss_ptr_p1[2:0]];
    assign next2_entry = mem[iss_ptr_p2[2:0]];
    assign next2_pc    = {next2_entry.start_pc, 1'b0};

endmodule

`default_nettype wire

//--- source/pq_bpu_req.sv
// BPU request control: one outstanding request, ack qualification, miss wait
`timescale 1ns/1ps
`default_nettype none

module pq_bpu_req (
    input  logic              core_clk,
    input  logic              core_reset_n,
    input  pq_pkg::flush_t    flush,
    input  logic              q_full,
    input  logic              bpu_rd_ready,
    input  logic              bpu_rd_ack,
    input  pq_pkg::bpu_info_t bpu_info,
    output logic              bpu_rd_valid,
    output logic              wr_en,
    output logic              no_addr_valid_stall
);
    import pq_pkg::*;

    logic outstanding;
    logic miss_wait;
    logic req_accept;
    logic ack_used;

    assign req_accept = bpu_rd_valid & bpu_rd_ready;
    // acks for a flushed request are dropped
    assign ack_used   = bpu_rd_ack & outstanding & ~flush.valid;
    assign wr_en      = ack_used & bpu_info.hit;

    assign bpu_rd_valid        = ~q_full & ~outstanding & ~miss_wait;
    assign no_addr_valid_stall = bpu_rd_valid & ~bpu_rd_ready;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            outstanding <= 1'b0;
        end else if (flush.valid) begin
            outstanding <= 1'b0;
        end else if (req_accept) begin
            outstanding <= 1'b1;
        end else if (ack_used) begin
            outstanding <= 1'b0;
        end
    end

    // nothing is requested until the first flush gives a start pc
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            miss_wait <= 1'b1;
        end else if (flush.valid) begin
            miss_wait <= 1'b0;
        end else if (ack_used & ~bpu_info.hit) begin
            miss_wait <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/pq_flush_ctrl.sv
// flush control: prioritized flush pc and the prediction-break flag
`timescale 1ns/1ps
`default_nettype none

module pq_flush_ctrl (
    input  logic            core_clk,
    input  logic            core_reset_n,
    input  logic            resume,
    input  pq_pkg::va_t     resume_pc,
    input  logic            redirect,
    input  logic            redirect_for_cti,
    input  pq_pkg::va_t     redirect_pc,
    input  logic            retry,
    input  pq_pkg::va_t     retry_pc,
    output pq_pkg::flush_t  flush,
    output logic            pred_brk
);
    import pq_pkg::*;

    logic brk_set;
    logic brk_clr;

    assign flush.valid = resume | redirect | retry;
    assign flush.pc    = resume ? resume_pc : redirect ? redirect_pc : retry_pc;

    // non-cti redirect or plain retry breaks the prediction stream
    assign brk_set = (redirect & ~redirect_for_cti) | (retry & ~redirect);
    assign brk_clr = resume | (redirect & redirect_for_cti);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            pred_brk <= 1'b0;
        end else if (brk_clr) begin
            pred_brk <= 1'b0;
        end else if (brk_set) begin
            pred_brk <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/pq_issue_pc.sv
// issue slot sequencing: slot pcs, per-slot prediction fields and pop count
`timescale 1ns/1ps
`default_nettype none

module pq_issue_pc (
    input  logic                core_clk,
    input  logic                core_reset_n,
    input  pq_pkg::flush_t      flush,
    input  pq_pkg::bblk_entry_t head_entry,
    input  pq_pkg::bblk_entry_t next_entry,
    input  pq_pkg::va_t         next2_pc,
    input  logic [2:0]          entry_cnt,
    input  pq_pkg::va_t         last_target,
    input  logic                ifu_i0_issue,
    input  logic                ifu_i0_32b,
    input  logic                ifu_i0_pred_hit,
    input  logic                ifu_i1_issue,
    input  logic                ifu_i1_32b,
    input  logic                ifu_i1_pred_hit,
    input  logic                ifu_i1_bblk_start,
    output pq_pkg::va_t         ifu_i0_pc,
    output pq_pkg::va_t         ifu_i1_pc,
    output pq_pkg::slot_pred_t  i0_pred,
    output pq_pkg::slot_pred_t  i1_pred,
    output logic [1:0]          pop_cnt
);
    import pq_pkg::*;

    va_t  i0_size;
    va_t  i1_size;
    va_t  pc_adv;
    va_t  head_npc;
    va_t  next_npc;
    logic head_valid;
    logic next_valid;

    function automatic slot_pred_t make_pred(input bblk_entry_t e, input logic vld,
                                             input logic hit, input va_t npc);
        slot_pred_t p;
        p.valid = vld;
        p.way   = e.way;
        p.taken = e.pred_taken & hit;
        p.ret   = e.ret;
        p.cnt   = e.cnt;
        p.npc   = npc;
        return p;
    endfunction

    assign i0_size = ifu_i0_32b ? 32'd4 : 32'd2;
    assign i1_size = ifu_i1_32b ? 32'd4 : 32'd2;
    assign pc_adv  = i0_size + (ifu_i1_issue ? i1_size : 32'd0);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            ifu_i0_pc <= '0;
        end else if (flush.valid) begin
            ifu_i0_pc <= flush.pc;
        end else if (ifu_i0_issue) begin
            ifu_i0_pc <= ifu_i0_pc + pc_adv;
        end
    end

    assign ifu_i1_pc = ifu_i0_pc + i0_size;

    assign head_valid = (entry_cnt != 3'd0);
    assign next_valid = (entry_cnt >= 3'd2);

    // fall back to the last hit target when no later block is queued
    assign head_npc = next_valid ? {next_entry.start_pc, 1'b0} : last_target;
    assign next_npc = (entry_cnt >= 3'd3) ? next2_pc : last_target;

    assign i0_pred = make_pred(head_entry, head_valid, ifu_i0_pred_hit, head_npc);
    assign i1_pred = ifu_i1_bblk_start ?
                     make_pred(next_entry, next_valid, ifu_i1_pred_hit, next_npc) :
                     make_pred(head_entry, head_valid, ifu_i1_pred_hit, head_npc);

    assign pop_cnt = {1'b0, ifu_i0_issue & ifu_i0_pred_hit}
                   + {1'b0, ifu_i1_issue & ifu_i1_pred_hit};

endmodule

`default_nettype wire

//--- source/pq_pkg.sv
// prediction queue package with address widths, queue geometry and bundle types
`default_nettype none

package pq_pkg;

    typedef logic [31:0] va_t;
    typedef logic [9:0]  bblk_offset_t;
    typedef logic [3:0]  pred_cnt_t;
    typedef logic [1:0]  hit_way_t;
    // 3-bit index plus wrap bit
    typedef logic [3:0]  pq_ptr_t;

    localparam int         PQ_DEPTH    = 5;
    localparam logic [2:0] PQ_LAST_IDX = 3'd4;

    // bit 0 of the start pc is always zero, not stored
    typedef struct packed {
        logic [30:0]  start_pc;
        bblk_offset_t offset;
        logic         pred_taken;
        hit_way_t     way;
        pred_cnt_t    cnt;
        logic         ret;
    } bblk_entry_t;

    typedef struct packed {
        bblk_entry_t entry;
        va_t         target;
        logic        hit;
    } bpu_info_t;

    typedef struct packed {
        logic valid;
        va_t  pc;
    } flush_t;

    typedef struct packed {
        logic      valid;
        hit_way_t  way;
        logic      taken;
        logic      ret;
        pred_cnt_t cnt;
        va_t       npc;
    } slot_pred_t;

endpackage

`default_nettype wire

//--- source/pq_top.sv
// prediction queue top: flush control, BPU requests, block queue and issue slots
`timescale 1ns/1ps
`default_nettype none

module pq_top (
    input  logic                 core_clk,
    input  logic                 core_reset_n,
    input  logic                 resume,
    input  pq_pkg::va_t          resume_pc,
    input  logic                 redirect,
    input  logic                 redirect_for_cti,
    input  pq_pkg::va_t          redirect_pc,
    input  logic                 retry,
    input  pq_pkg::va_t          retry_pc,
    input  logic                 bpu_rd_ready,
    input  logic                 bpu_rd_ack,
    input  logic                 bpu_info_hit,
    input  pq_pkg::va_t          bpu_info_target,
    input  pq_pkg::va_t          bpu_info_start_pc,
    input  pq_pkg::bblk_offset_t bpu_info_offset,
    input  pq_pkg::hit_way_t     bpu_info_way,
    input  logic                 bpu_info_ret,
    input  logic                 bpu_info_pred_taken,
    input  pq_pkg::pred_cnt_t    bpu_info_pred_cnt,
    input  logic                 ifu_i0_issue,
    input  logic                 ifu_i0_32b,
    input  logic                 ifu_i0_pred_hit,
    input  logic                 ifu_i1_issue,
    input  logic                 ifu_i1_32b,
    input  logic                 ifu_i1_pred_hit,
    input  logic                 ifu_i1_bblk_start,
    output logic                 bpu_rd_valid,
    output logic                 no_addr_valid_stall,
    output pq_pkg::va_t          ifu_i0_pc,
    output logic                 ifu_i0_pred_valid,
    output pq_pkg::hit_way_t     ifu_i0_pred_way,
    output logic                 ifu_i0_pred_taken,
    output logic                 ifu_i0_pred_ret,
    output pq_pkg::pred_cnt_t    ifu_i0_pred_cnt,
    output pq_pkg::va_t          ifu_i0_pred_npc,
    output logic                 ifu_i0_pred_brk,
    output pq_pkg::va_t          ifu_i1_pc,
    output logic                 ifu_i1_pred_valid,
    output pq_pkg::hit_way_t     ifu_i1_pred_way,
    output logic                 ifu_i1_pred_taken,
    output logic                 ifu_i1_pred_ret,
    output pq_pkg::pred_cnt_t    ifu_i1_pred_cnt,
    output pq_pkg::va_t          ifu_i1_pred_npc
);
    import pq_pkg::*;

    flush_t      flush;
    bpu_info_t   bpu_info;
    logic        q_full;
    logic        wr_en;
    logic [2:0]  entry_cnt;
    logic [1:0]  pop_cnt;
    bblk_entry_t head_entry;
    bblk_entry_t next_entry;
    va_t         next2_pc;
    va_t         last_target;
    slot_pred_t  i0_pred;
    slot_pred_t  i1_pred;

    assign bpu_info.entry.start_pc   = bpu_info_start_pc[31:1];
    assign bpu_info.entry.offset     = bpu_info_offset;
    assign bpu_info.entry.pred_taken = bpu_info_pred_taken;
    assign bpu_info.entry.way        = bpu_info_way;
    assign bpu_info.entry.cnt        = bpu_info_pred_cnt;
    assign bpu_info.entry.ret        = bpu_info_ret;
    assign bpu_info.target           = bpu_info_target;
    assign bpu_info.hit              = bpu_info_hit;

    pq_flush_ctrl u_flush_ctrl (
        .core_clk         (core_clk),
        .core_reset_n     (core_reset_n),
        .resume           (resume),
        .resume_pc        (resume_pc),
        .redirect         (redirect),
        .redirect_for_cti (redirect_for_cti),
        .redirect_pc      (redirect_pc),
        .retry            (retry),
        .retry_pc         (retry_pc),
        .flush            (flush),
        .pred_brk         (ifu_i0_pred_brk)
    );

    pq_bpu_req u_bpu_req (
        .core_clk            (core_clk),
        .core_reset_n        (core_reset_n),
        .flush               (flush),
        .q_full              (q_full),
        .bpu_rd_ready        (bpu_rd_ready),
        .bpu_rd_ack          (bpu_rd_ack),
        .bpu_info            (bpu_info),
        .bpu_rd_valid        (bpu_rd_valid),
        .wr_en               (wr_en),
        .no_addr_valid_stall (no_addr_valid_stall)
    );

    pq_bblk_queue u_bblk_queue (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .flush        (flush),
        .wr_en        (wr_en),
        .bpu_info     (bpu_info),
        .pop_cnt      (pop_cnt),
        .q_full       (q_full),
        .entry_cnt    (entry_cnt),
        .head_entry   (head_entry),
        .next_entry   (next_entry),
        .next2_pc     (next2_pc),
        .last_target  (last_target)
    );

    pq_issue_pc u_issue_pc (
        .core_clk          (core_clk),
        .core_reset_n      (core_reset_n),
        .flush             (flush),
        .head_entry        (head_entry),
        .next_entry        (next_entry),
        .next2_pc          (next2_pc),
        .entry_cnt         (entry_cnt),
        .last_target       (last_target),
        .ifu_i0_issue      (ifu_i0_issue),
        .ifu_i0_32b        (ifu_i0_32b),
        .ifu_i0_pred_hit   (ifu_i0_pred_hit),
        .ifu_i1_issue      (ifu_i1_issue),
        .ifu_i1_32b        (ifu_i1_32b),
        .ifu_i1_pred_hit   (ifu_i1_pred_hit),
        .ifu_i1_bblk_start (ifu_i1_bblk_start),
        .ifu_i0_pc         (ifu_i0_pc),
        .ifu_i1_pc         (ifu_i1_pc),
        .i0_pred           (i0_pred),
        .i1_pred           (i1_pred),
        .pop_cnt           (pop_cnt)
    );

    assign ifu_i0_pred_valid = i0_pred.valid;
    assign ifu_i0_pred_way   = i0_pred.way;
    assign ifu_i0_pred_taken = i0_pred.taken;
    assign ifu_i0_pred_ret   = i0_pred.ret;
    assign ifu_i0_pred_cnt   = i0_pred.cnt;
    assign ifu_i0_pred_npc   = i0_pred.npc;

    assign ifu_i1_pred_valid = i1_pred.valid;
    assign ifu_i1_pred_way   = i1_pred.way;
    assign ifu_i1_pred_taken = i1_pred.taken;
    assign ifu_i1_pred_ret   = i1_pred.ret;
    assign ifu_i1_pred_cnt   = i1_pred.cnt;
    assign ifu_i1_pred_npc   = i1_pred.npc;

endmodule

`default_nettype wire
